// File: verilog/acc_proc_pkg.sv
package acc_proc_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	// Accumulator, RAM and I/O byte width
	localparam int DATA_W = 8;
	// Program word width
	localparam int INSTR_W = 16;

	// Instruction word fields
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 8;
	localparam int OPD_HI = 7;
	localparam int OPD_LO = 0;

	////////////////////////////////////////
	// Instruction set
	////////////////////////////////////////

	// Any code not listed here halts as illegal
	typedef enum logic [7:0] {
		OP_NOP  = 8'h00,
		OP_LDI  = 8'h01,
		OP_LDM  = 8'h02,
		OP_STM  = 8'h03,
		OP_ADDI = 8'h10,
		OP_SUBI = 8'h11,
		OP_ANDI = 8'h12,
		OP_ORI  = 8'h13,
		OP_XORI = 8'h14,
		OP_ADDM = 8'h18,
		OP_SUBM = 8'h19,
		OP_SHL  = 8'h20,
		OP_SHR  = 8'h21,
		OP_JMP  = 8'h30,
		OP_JZ   = 8'h31,
		OP_JC   = 8'h32,
		OP_IN   = 8'h40,
		OP_OUT  = 8'h41,
		OP_HALT = 8'hFF
	} opcode_t;

	// ALU functions, PASS forwards operand b
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS
	} alu_op_t;

endpackage

// File: verilog/alu_unit.sv
`timescale 1ns/10ps

module alu_unit
	import acc_proc_pkg::*;
(
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  alu_op_t           op,
	output logic [DATA_W-1:0] result,
	output logic              c,
	output logic              v,
	output logic              z
);

	logic [DATA_W:0] sum;
	logic [DATA_W:0] diff;

	// Extra top bit holds carry or borrow
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = '0;
		c      = 1'b0;
		v      = 1'b0;
		case (op)
			ALU_ADD: begin
				result = sum[DATA_W-1:0];
				c      = sum[DATA_W];
				// Same-sign operands, result sign flipped
				v = (a[DATA_W-1] == b[DATA_W-1]) &&
					(result[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_SUB: begin
				result = diff[DATA_W-1:0];
				c      = diff[DATA_W];
				// Opposite-sign operands, result sign differs from a
				v = (a[DATA_W-1] != b[DATA_W-1]) &&
					(result[DATA_W-1] != a[DATA_W-1]);
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// Single-bit shifts, zero fill
			ALU_SHL: begin
				result = {a[DATA_W-2:0], 1'b0};
				c      = a[DATA_W-1];
			end
			ALU_SHR: begin
				result = {1'b0, a[DATA_W-1:1]};
				c      = a[0];
			end
			ALU_PASS: result = b;
		endcase
	end

	assign z = (result == '0);

endmodule

// File: verilog/data_ram.sv
`timescale 1ns/10ps

module data_ram
	import acc_proc_pkg::*;
#(
	parameter int DMEM_AW = 4
) (
	input  logic               g_clk,
	input  logic               reset,
	input  logic               we,
	input  logic [DMEM_AW-1:0] addr,
	input  logic [DATA_W-1:0]  wdata,
	output logic [DATA_W-1:0]  rdata
);

	logic [DATA_W-1:0] mem [2**DMEM_AW];

	// Cleared on reset, written on the STM cycle
	always_ff @(posedge g_clk) begin
		if (reset) begin
			for (int i = 0; i < 2**DMEM_AW; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

	// Same-cycle read for LDM, ADDM, SUBM
	assign rdata = mem[addr];

endmodule

// File: verilog/io_port.sv
`timescale 1ns/10ps

module io_port
	import acc_proc_pkg::*;
(
	input  logic              g_clk,
	input  logic              reset,
	input  logic              in_dev_hs,
	input  logic [DATA_W-1:0] input_bus,
	input  logic              in_take,
	input  logic              out_dev_hs,
	input  logic              out_dev_ack,
	input  logic              out_strobe,
	input  logic [DATA_W-1:0] out_data,
	output logic              in_dev_ack,
	output logic              in_full,
	output logic [DATA_W-1:0] in_data,
	output logic [DATA_W-1:0] output_bus,
	output logic              out_dev_valid,
	output logic              out_busy
);

	typedef enum logic [1:0] {
		OS_IDLE,
		OS_WAIT_RDY,
		OS_SEND
	} out_state_t;

	out_state_t        out_state;
	logic [DATA_W-1:0] out_buf;
	logic              in_armed;

	////////////////////////////////////////
	// Input side
	////////////////////////////////////////

	// Armed again only after device drops hs, so one byte per handshake
	always_ff @(posedge g_clk) begin
		if (reset) begin
			in_full    <= 1'b0;
			in_armed   <= 1'b1;
			in_dev_ack <= 1'b0;
		end else begin
			in_dev_ack <= 1'b0;
			if (!in_dev_hs) in_armed <= 1'b1;
			if (in_dev_hs && in_armed && !in_full) begin
				in_full    <= 1'b1;
				in_armed   <= 1'b0;
				in_dev_ack <= 1'b1;
			end else if (in_take) begin
				in_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge g_clk) begin
		if (in_dev_hs && in_armed && !in_full) in_data <= input_bus;
	end

	////////////////////////////////////////
	// Output side
	////////////////////////////////////////

	always_ff @(posedge g_clk) begin
		if (reset) begin
			out_state     <= OS_IDLE;
			out_dev_valid <= 1'b0;
		end else begin
			case (out_state)
				OS_IDLE: if (out_strobe) out_state <= OS_WAIT_RDY;
				// Hold byte until device says it can take it
				OS_WAIT_RDY: begin
					if (out_dev_hs) begin
						out_state     <= OS_SEND;
						out_dev_valid <= 1'b1;
					end
				end
				OS_SEND: begin
					if (out_dev_ack) begin
						out_state     <= OS_IDLE;
						out_dev_valid <= 1'b0;
					end
				end
				default: out_state <= OS_IDLE;
			endcase
		end
	end

	always_ff @(posedge g_clk) begin
		if (out_strobe && out_state == OS_IDLE) out_buf <= out_data;
	end

	assign out_busy   = (out_state != OS_IDLE);
	assign output_bus = (out_state == OS_SEND) ? out_buf : '0;

endmodule

// File: verilog/instr_fetch.sv
`timescale 1ns/10ps

module instr_fetch
	import acc_proc_pkg::*;
#(
	parameter int IMEM_AW = 5
) (
	input  logic               g_clk,
	input  logic               reset,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  logic [INSTR_W-1:0] prog_data,
	input  logic               start,
	input  logic               run,
	input  logic               stall,
	input  logic               redirect,
	input  logic [DATA_W-1:0]  redirect_addr,
	output logic               stage0_valid,
	output logic [INSTR_W-1:0] stage0_word,
	output logic [IMEM_AW-1:0] pc
);

	////////////////////////////////////////
	// Program memory
	////////////////////////////////////////

	logic [INSTR_W-1:0] imem [2**IMEM_AW];

	// Loading only allowed while core is stopped
	always_ff @(posedge g_clk) begin
		if (prog_we && !run) begin
			imem[prog_addr] <= prog_data;
		end
	end

	////////////////////////////////////////
	// PC and stage 0
	////////////////////////////////////////

	always_ff @(posedge g_clk) begin
		if (reset) begin
			pc           <= '0;
			stage0_valid <= 1'b0;
		end else if (start) begin
			// Restart from address 0 with empty stage
			pc           <= '0;
			stage0_valid <= 1'b0;
		end else if (redirect) begin
			// Taken jump, drop the word behind it
			pc           <= redirect_addr[IMEM_AW-1:0];
			stage0_valid <= 1'b0;
		end else if (stall) begin
			// Execute busy on I/O, freeze
			pc           <= pc;
			stage0_valid <= stage0_valid;
		end else if (run) begin
			pc           <= pc + 1'b1;
			stage0_valid <= 1'b1;
		end else begin
			stage0_valid <= 1'b0;
		end
	end

	// Instruction payload, qualified by stage0_valid
	always_ff @(posedge g_clk) begin
		if (run && !start && !redirect && !stall) begin
			stage0_word <= imem[pc];
		end
	end

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/10ps

module exec_stage
	import acc_proc_pkg::*;
#(
	parameter int DMEM_AW = 4
) (
	input  logic               g_clk,
	input  logic               reset,
	input  logic               start,
	input  logic               stage0_valid,
	input  logic [INSTR_W-1:0] stage0_word,
	input  logic [DATA_W-1:0]  alu_result,
	input  logic               alu_c,
	input  logic               alu_v,
	input  logic               alu_z,
	input  logic [DATA_W-1:0]  ram_rdata,
	input  logic               in_full,
	input  logic [DATA_W-1:0]  in_data,
	input  logic               out_busy,
	output logic               run,
	output logic               halted,
	output logic               illegal,
	output logic               stall,
	output logic               redirect,
	output logic [DATA_W-1:0]  redirect_addr,
	output alu_op_t            alu_op,
	output logic [DATA_W-1:0]  alu_b,
	output logic [DATA_W-1:0]  acc,
	output logic               flag_c,
	output logic               flag_v,
	output logic               flag_z,
	output logic               ram_we,
	output logic [DATA_W-1:0]  ram_wdata,
	output logic [DMEM_AW-1:0] ram_addr,
	output logic               in_take,
	output logic               out_strobe,
	output logic [DATA_W-1:0]  out_data
);

	typedef enum logic {
		RS_HALT,
		RS_RUN
	} run_state_t;

	run_state_t        run_state;
	opcode_t           opc;
	logic [DATA_W-1:0] operand;
	logic              exe;
	logic              acc_we;
	logic              halt_req;
	logic              bad_op;

	// Field split of the stage 0 word
	assign opc     = opcode_t'(stage0_word[OPC_HI:OPC_LO]);
	assign operand = stage0_word[OPD_HI:OPD_LO];
	assign exe     = (run_state == RS_RUN) && stage0_valid;

	assign run    = (run_state == RS_RUN);
	assign halted = (run_state == RS_HALT);

	// Operand byte doubles as jump target and RAM address
	assign redirect_addr = operand;
	assign ram_addr      = operand[DMEM_AW-1:0];
	assign ram_wdata     = acc;
	assign out_data      = acc;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	always_comb begin
		alu_op     = ALU_PASS;
		alu_b      = operand;
		acc_we     = 1'b0;
		ram_we     = 1'b0;
		redirect   = 1'b0;
		stall      = 1'b0;
		in_take    = 1'b0;
		out_strobe = 1'b0;
		halt_req   = 1'b0;
		bad_op     = 1'b0;
		if (exe) begin
			case (opc)
				OP_NOP: ;
				// Loads go through ALU PASS, which gives the load flag rule
				OP_LDI: acc_we = 1'b1;
				OP_LDM: begin
					alu_b  = ram_rdata;
					acc_we = 1'b1;
				end
				OP_STM: ram_we = 1'b1;
				OP_ADDI: begin
					alu_op = ALU_ADD;
					acc_we = 1'b1;
				end
				OP_SUBI: begin
					alu_op = ALU_SUB;
					acc_we = 1'b1;
				end
				OP_ANDI: begin
					alu_op = ALU_AND;
					acc_we = 1'b1;
				end
				OP_ORI: begin
					alu_op = ALU_OR;
					acc_we = 1'b1;
				end
				OP_XORI: begin
					alu_op = ALU_XOR;
					acc_we = 1'b1;
				end
				OP_ADDM: begin
					alu_op = ALU_ADD;
					alu_b  = ram_rdata;
					acc_we = 1'b1;
				end
				OP_SUBM: begin
					alu_op = ALU_SUB;
					alu_b  = ram_rdata;
					acc_we = 1'b1;
				end
				OP_SHL: begin
					alu_op = ALU_SHL;
					acc_we = 1'b1;
				end
				OP_SHR: begin
					alu_op = ALU_SHR;
					acc_we = 1'b1;
				end
				OP_JMP: redirect = 1'b1;
				OP_JZ:  redirect = flag_z;
				OP_JC:  redirect = flag_c;
				// Wait for a buffered input byte
				OP_IN: begin
					if (in_full) begin
						alu_b   = in_data;
						acc_we  = 1'b1;
						in_take = 1'b1;
					end else begin
						stall = 1'b1;
					end
				end
				// Wait for output buffer to drain
				OP_OUT: begin
					if (out_busy) stall = 1'b1;
					else out_strobe = 1'b1;
				end
				// Halt only once the last output byte has left
				OP_HALT: begin
					if (out_busy) stall = 1'b1;
					else halt_req = 1'b1;
				end
				default: begin
					if (out_busy) begin
						stall = 1'b1;
					end else begin
						halt_req = 1'b1;
						bad_op   = 1'b1;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Run state, accumulator, flags
	////////////////////////////////////////

	always_ff @(posedge g_clk) begin
		if (reset) begin
			run_state <= RS_HALT;
			illegal   <= 1'b0;
			acc       <= '0;
			flag_c    <= 1'b0;
			flag_v    <= 1'b0;
			flag_z    <= 1'b0;
		end else begin
			if (start) begin
				run_state <= RS_RUN;
				illegal   <= 1'b0;
			end else if (halt_req) begin
				run_state <= RS_HALT;
				// Sticky until next start
				if (bad_op) illegal <= 1'b1;
			end
			if (acc_we) begin
				acc    <= alu_result;
				flag_c <= alu_c;
				flag_v <= alu_v;
				flag_z <= alu_z;
			end
		end
	end

endmodule

// File: verilog/processor.sv
`timescale 1ns/10ps

module processor
	import acc_proc_pkg::*;
#(
	parameter int IMEM_AW = 5,
	parameter int DMEM_AW = 4
) (
	input  logic               g_clk,
	input  logic               reset,
	input  logic               prog_we,
	input  logic [IMEM_AW-1:0] prog_addr,
	input  logic [INSTR_W-1:0] prog_data,
	input  logic               start,
	input  logic               in_dev_hs,
	input  logic [DATA_W-1:0]  input_bus,
	input  logic               out_dev_hs,
	input  logic               out_dev_ack,
	output logic               halted,
	output logic               illegal,
	output logic               in_dev_ack,
	output logic [DATA_W-1:0]  output_bus,
	output logic               out_dev_valid,
	output logic [DATA_W-1:0]  acc_reg_out,
	output logic [IMEM_AW-1:0] pc_output,
	output logic               C,
	output logic               V,
	output logic               Z
);

	////////////////////////////////////////
	// Interconnect
	////////////////////////////////////////

	// Pipeline control
	logic               run;
	logic               stall;
	logic               redirect;
	logic [DATA_W-1:0]  redirect_addr;
	logic               stage0_valid;
	logic [INSTR_W-1:0] stage0_word;
	// ALU
	alu_op_t            alu_op;
	logic [DATA_W-1:0]  alu_b;
	logic [DATA_W-1:0]  alu_result;
	logic               alu_c;
	logic               alu_v;
	logic               alu_z;
	// Data RAM
	logic               ram_we;
	logic [DMEM_AW-1:0] ram_addr;
	logic [DATA_W-1:0]  ram_wdata;
	logic [DATA_W-1:0]  ram_rdata;
	// Core side of I/O
	logic               in_full;
	logic               in_take;
	logic [DATA_W-1:0]  in_data;
	logic               out_busy;
	logic               out_strobe;
	logic [DATA_W-1:0]  out_data;

	instr_fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
		.g_clk(g_clk), .reset(reset),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.start(start), .run(run), .stall(stall),
		.redirect(redirect), .redirect_addr(redirect_addr),
		.stage0_valid(stage0_valid), .stage0_word(stage0_word), .pc(pc_output)
	);

	exec_stage #(.DMEM_AW(DMEM_AW)) u_exec (
		.g_clk(g_clk), .reset(reset), .start(start),
		.stage0_valid(stage0_valid), .stage0_word(stage0_word),
		.alu_result(alu_result), .alu_c(alu_c), .alu_v(alu_v), .alu_z(alu_z),
		.ram_rdata(ram_rdata), .in_full(in_full), .in_data(in_data),
		.out_busy(out_busy), .run(run), .halted(halted), .illegal(illegal),
		.stall(stall), .redirect(redirect), .redirect_addr(redirect_addr),
		.alu_op(alu_op), .alu_b(alu_b), .acc(acc_reg_out),
		.flag_c(C), .flag_v(V), .flag_z(Z),
		.ram_we(ram_we), .ram_wdata(ram_wdata), .ram_addr(ram_addr),
		.in_take(in_take), .out_strobe(out_strobe), .out_data(out_data)
	);

	// Accumulator is always operand a
	alu_unit u_alu (
		.a(acc_reg_out), .b(alu_b), .op(alu_op),
		.result(alu_result), .c(alu_c), .v(alu_v), .z(alu_z)
	);

	data_ram #(.DMEM_AW(DMEM_AW)) u_ram (
		.g_clk(g_clk), .reset(reset), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata)
	);

	io_port u_io (
		.g_clk(g_clk), .reset(reset),
		.in_dev_hs(in_dev_hs), .input_bus(input_bus), .in_take(in_take),
		.out_dev_hs(out_dev_hs), .out_dev_ack(out_dev_ack),
		.out_strobe(out_strobe), .out_data(out_data),
		.in_dev_ack(in_dev_ack), .in_full(in_full), .in_data(in_data),
		.output_bus(output_bus), .out_dev_valid(out_dev_valid), .out_busy(out_busy)
	);

endmodule

// File: tests/processor_tb.sv
`timescale 1ns/10ps

module processor_tb
	import acc_proc_pkg::*;
();

	localparam int IMEM_AW     = 5;
	localparam int DMEM_AW     = 4;
	localparam int NUM_CASES   = 9;
	localparam int MAX_WORDS   = 16;
	localparam int MAX_BYTES   = 4;
	localparam int CYCLE_LIMIT = 200 * NUM_CASES;
	localparam logic [31:0] SEED = 32'h5999_8469;

	// DUT pins
	logic               g_clk;
	logic               reset;
	logic               prog_we;
	logic [IMEM_AW-1:0] prog_addr;
	logic [INSTR_W-1:0] prog_data;
	logic               start;
	logic               in_dev_hs;
	logic [DATA_W-1:0]  input_bus;
	logic               out_dev_hs;
	logic               out_dev_ack;
	logic               halted;
	logic               illegal;
	logic               in_dev_ack;
	logic [DATA_W-1:0]  output_bus;
	logic               out_dev_valid;
	logic [DATA_W-1:0]  acc_reg_out;
	logic [IMEM_AW-1:0] pc_output;
	logic               flag_c;
	logic               flag_v;
	logic               flag_z;

	// Case table
	string       case_name [NUM_CASES];
	logic [15:0] prog_word [NUM_CASES][MAX_WORDS];
	logic [7:0]  in_byte   [NUM_CASES][MAX_BYTES];
	logic [7:0]  out_byte  [NUM_CASES][MAX_BYTES];
	int          n_in      [NUM_CASES];
	int          n_out     [NUM_CASES];
	logic [7:0]  exp_acc   [NUM_CASES];
	logic [2:0]  exp_cvz   [NUM_CASES];
	logic        exp_ill   [NUM_CASES];
	int          exp_pc    [NUM_CASES];
	int          n_cases;
	int          cur;
	int          n_words;

	int          checks;
	int          errors;
	int          cycle_count;

	processor #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_dut (
		.g_clk(g_clk), .reset(reset),
		.prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
		.start(start), .in_dev_hs(in_dev_hs), .input_bus(input_bus),
		.out_dev_hs(out_dev_hs), .out_dev_ack(out_dev_ack),
		.halted(halted), .illegal(illegal), .in_dev_ack(in_dev_ack),
		.output_bus(output_bus), .out_dev_valid(out_dev_valid),
		.acc_reg_out(acc_reg_out), .pc_output(pc_output),
		.C(flag_c), .V(flag_v), .Z(flag_z)
	);

	always #5 g_clk = ~g_clk;

	// Watchdog over the whole run
	always @(posedge g_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the core did not finish all cases within %0d cycles",
				CYCLE_LIMIT);
			$display("checks %0d, errors %0d", checks, errors);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Table building
	////////////////////////////////////////

	// Bytes packed with the first one in the top byte
	function automatic void open_case(input string name, input int ni,
		input logic [31:0] ins, input int no, input logic [31:0] outs,
		input logic [7:0] acc, input logic [2:0] cvz, input logic ill,
		input int end_pc);
		cur            = n_cases;
		case_name[cur] = name;
		n_in[cur]      = ni;
		n_out[cur]     = no;
		exp_acc[cur]   = acc;
		exp_cvz[cur]   = cvz;
		exp_ill[cur]   = ill;
		exp_pc[cur]    = end_pc;
		for (int k = 0; k < MAX_BYTES; k++) begin
			in_byte[cur][k]  = ins[31-8*k -: 8];
			out_byte[cur][k] = outs[31-8*k -: 8];
		end
		// Unused program words halt
		for (int k = 0; k < MAX_WORDS; k++) begin
			prog_word[cur][k] = {OP_HALT, 8'h00};
		end
		n_cases = n_cases + 1;
		n_words = 0;
	endfunction

	function automatic void add_words(input logic [15:0] w0, input logic [15:0] w1,
		input logic [15:0] w2, input logic [15:0] w3);
		prog_word[cur][n_words]     = w0;
		prog_word[cur][n_words + 1] = w1;
		prog_word[cur][n_words + 2] = w2;
		prog_word[cur][n_words + 3] = w3;
		n_words = n_words + 4;
	endfunction

	// Columns are name, input count and bytes, output count and bytes, acc, CVZ, illegal, end PC
	// End PC sits two past the halting word, fetch still steps on the halt edge
	function automatic void build_table();
		n_cases = 0;
		// 7F+1 sets V, 80+80 and FF+1 carry to zero, 0-1 borrows
		open_case("alu_add", 0, 32'h0, 4, 32'h8000_00FF, 8'hFF, 3'b100, 1'b0, 12);
		add_words({OP_LDI, 8'h7F}, {OP_ADDI, 8'h01}, {OP_OUT, 8'h00}, {OP_ADDI, 8'h80});
		add_words({OP_OUT, 8'h00}, {OP_LDI, 8'hFF}, {OP_ADDI, 8'h01}, {OP_OUT, 8'h00});
		add_words({OP_SUBI, 8'h01}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
		// Logic ops then shifts with the bit shifted out in C
		open_case("alu_logic_shift", 0, 32'h0, 4, 32'h30CA_9412, 8'h00, 3'b001, 1'b0, 15);
		add_words({OP_LDI, 8'hF0}, {OP_ANDI, 8'h3C}, {OP_OUT, 8'h00}, {OP_ORI, 8'h05});
		add_words({OP_XORI, 8'hFF}, {OP_OUT, 8'h00}, {OP_SHL, 8'h00}, {OP_OUT, 8'h00});
		add_words({OP_SHR, 8'h00}, {OP_SHR, 8'h00}, {OP_SHR, 8'h00}, {OP_OUT, 8'h00});
		add_words({OP_ANDI, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
		// 80-1 is a signed overflow
		open_case("sub_overflow", 0, 32'h0, 1, 32'h7F00_0000, 8'h7F, 3'b010, 1'b0, 5);
		add_words({OP_LDI, 8'h80}, {OP_SUBI, 8'h01}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00});
		// Address 1F aliases to byte F
		open_case("data_ram", 0, 32'h0, 4, 32'h257F_EF95, 8'h95, 3'b000, 1'b0, 16);
		add_words({OP_LDI, 8'h25}, {OP_STM, 8'h03}, {OP_LDI, 8'h5A}, {OP_STM, 8'h09});
		add_words({OP_LDI, 8'h90}, {OP_STM, 8'h1F}, {OP_LDM, 8'h03}, {OP_OUT, 8'h00});
		add_words({OP_ADDM, 8'h09}, {OP_OUT, 8'h00}, {OP_SUBM, 8'h1F}, {OP_OUT, 8'h00});
		add_words({OP_SUBM, 8'h09}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
		// Every skipped OUT would add a byte
		open_case("jumps", 0, 32'h0, 2, 32'h0504_0000, 8'h04, 3'b100, 1'b0, 16);
		add_words({OP_LDI, 8'h01}, {OP_JMP, 8'h03}, {OP_OUT, 8'h00}, {OP_ANDI, 8'h00});
		add_words({OP_JC, 8'h06}, {OP_JZ, 8'h07}, {OP_OUT, 8'h00}, {OP_LDI, 8'h05});
		add_words({OP_JZ, 8'h0A}, {OP_OUT, 8'h00}, {OP_ADDI, 8'hFF}, {OP_JC, 8'h0D});
		add_words({OP_OUT, 8'h00}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
		// Count down from 3 to 0
		open_case("count_loop", 0, 32'h0, 4, 32'h0302_0100, 8'h00, 3'b001, 1'b0, 8);
		add_words({OP_LDI, 8'h03}, {OP_OUT, 8'h00}, {OP_SUBI, 8'h01}, {OP_JZ, 8'h05});
		add_words({OP_JMP, 8'h01}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
		// Echo plus one, last IN clears the carry left by FF+1
		open_case("input_echo", 4, 32'h107F_FF00, 4, 32'h1180_0000, 8'h00, 3'b001, 1'b0, 13);
		add_words({OP_IN, 8'h00}, {OP_ADDI, 8'h01}, {OP_OUT, 8'h00}, {OP_IN, 8'h00});
		add_words({OP_ADDI, 8'h01}, {OP_OUT, 8'h00}, {OP_IN, 8'h00}, {OP_ADDI, 8'h01});
		add_words({OP_OUT, 8'h00}, {OP_IN, 8'h00}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00});
		// Opcode 77 is not in the set
		open_case("illegal_op", 0, 32'h0, 1, 32'h3300_0000, 8'h33, 3'b000, 1'b1, 4);
		add_words({OP_LDI, 8'h33}, {OP_OUT, 8'h00}, {8'h77, 8'h00}, {OP_LDI, 8'h44});
		add_words({OP_OUT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
		open_case("restart", 0, 32'h0, 1, 32'h2A00_0000, 8'h2A, 3'b000, 1'b0, 4);
		add_words({OP_LDI, 8'h2A}, {OP_OUT, 8'h00}, {OP_HALT, 8'h00}, {OP_HALT, 8'h00});
	endfunction

	////////////////////////////////////////
	// Checking and case runner
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual) begin
			errors = errors + 1;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic run_case(input int i);
		logic [7:0] got [MAX_BYTES];
		int         n_got;
		int         acks;
		int         in_idx;
		int         delay;
		n_got  = 0;
		acks   = 0;
		in_idx = 0;
		delay  = $urandom % 4;
		// Program load while halted
		for (int k = 0; k < MAX_WORDS; k++) begin
			@(negedge g_clk);
			prog_we   = 1'b1;
			prog_addr = k[IMEM_AW-1:0];
			prog_data = prog_word[i][k];
		end
		@(negedge g_clk);
		prog_we = 1'b0;
		start   = 1'b1;
		@(negedge g_clk);
		start = 1'b0;
		while (!halted) begin
			// Input device offers the next byte once the last ack is done
			if (in_dev_ack) acks++;
			if (in_dev_hs && in_dev_ack) begin
				in_dev_hs = 1'b0;
				in_idx++;
			end else if (!in_dev_hs && in_idx < n_in[i]) begin
				input_bus = in_byte[i][in_idx];
				in_dev_hs = 1'b1;
			end
			// Output device waits 0 to 3 cycles before each hs
			if (out_dev_ack) begin
				out_dev_ack = 1'b0;
				out_dev_hs  = 1'b0;
				delay       = $urandom % 4;
			end else if (!out_dev_hs) begin
				if (delay == 0) out_dev_hs = 1'b1;
				else delay--;
			end else if (out_dev_valid) begin
				if (n_got < MAX_BYTES) got[n_got] = output_bus;
				n_got++;
				out_dev_ack = 1'b1;
			end
			@(negedge g_clk);
		end
		// All bytes must be out by the time halted rises
		check_value({case_name[i], " output count"}, n_out[i], n_got);
		for (int k = 0; k < n_out[i] && k < n_got; k++) begin
			check_value($sformatf("%s output %0d", case_name[i], k),
				out_byte[i][k], got[k]);
		end
		check_value({case_name[i], " input acks"}, n_in[i], acks);
		check_value({case_name[i], " acc"}, exp_acc[i], acc_reg_out);
		check_value({case_name[i], " flags CVZ"}, exp_cvz[i], {flag_c, flag_v, flag_z});
		check_value({case_name[i], " illegal"}, exp_ill[i], illegal);
		check_value({case_name[i], " pc"}, exp_pc[i], pc_output);
		in_dev_hs   = 1'b0;
		out_dev_hs  = 1'b0;
		out_dev_ack = 1'b0;
	endtask

	initial begin
		void'($urandom(SEED));
		checks      = 0;
		errors      = 0;
		cycle_count = 0;
		g_clk       = 1'b0;
		reset       = 1'b1;
		prog_we     = 1'b0;
		prog_addr   = '0;
		prog_data   = '0;
		start       = 1'b0;
		in_dev_hs   = 1'b0;
		input_bus   = '0;
		out_dev_hs  = 1'b0;
		out_dev_ack = 1'b0;
		build_table();
		repeat (2) @(negedge g_clk);
		reset = 1'b0;
		for (int i = 0; i < n_cases; i++) begin
			run_case(i);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: tb.f
verilog/acc_proc_pkg.sv
verilog/alu_unit.sv
verilog/data_ram.sv
verilog/io_port.sv
verilog/instr_fetch.sv
verilog/exec_stage.sv
verilog/processor.sv
tests/processor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the processor testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f tb.f \
	--top-module processor_tb \
	-o processor_tb

# Simulation output goes to sim.log
./obj_dir/processor_tb | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
